// File: hdl/board_io_pkg.sv
`default_nettype none

package board_io_pkg;

  // word address width on the bus
  localparam int ADDR_W = 12;

  typedef logic [ADDR_W-1:0] bus_addr_t;
  typedef logic [15:0]       bus_data_t;

  // i/o register map, window is 0x080 to 0x0ff
  localparam bus_addr_t IO_LEDLCD_ADDR = 12'h080;
  localparam bus_addr_t IO_LCD_ADDR    = 12'h081;
  localparam bus_addr_t IO_GPIO_ADDR   = 12'h082;

  typedef enum logic [1:0] {
    region_ram,
    region_io,
    region_none
  } region_t;

  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } byte_pair_t;

  // one bus word, seen whole or as two byte lanes
  typedef union packed {
    bus_data_t  half;
    byte_pair_t bytes;
  } data_word_u;

  typedef struct packed {
    logic       wr;
    logic [1:0] strb;
    region_t    region;
    bus_addr_t  addr;
    data_word_u wdata;
  } bus_req_t;

  // everything the scanner and the pin drive need
  typedef struct packed {
    bus_data_t   last_wdata;
    logic [15:0] last_addr;
    logic [7:0]  led;
    logic [7:0]  lcd;
    logic [7:0]  gpio;
  } display_t;

endpackage

`default_nettype wire

// File: hdl/apb_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module apb_mem_port
  import board_io_pkg::*;
#(
  parameter int RAM_DEPTH = 1024
) (
  input  wire logic       sys_clk,
  input  wire logic       rst_n,
  input  wire logic       psel,
  input  wire logic       penable,
  input  wire logic       pwrite,
  input  wire bus_addr_t  paddr,
  input  wire bus_data_t  pwdata,
  input  wire logic [1:0] pstrb,
  output bus_data_t       prdata,
  output logic            pready,
  output bus_req_t        req,
  input  wire bus_data_t  ram_rdata,
  input  wire bus_data_t  io_rdata
);

  logic    first_access;
  logic    rd_wait_q;
  region_t region;
  region_t rd_region_q;

  // 0x080..0x0ff is the i/o window, it shadows ram
  always_comb begin
    if (paddr[ADDR_W-1:7] == 5'b00001) begin
      region = region_io;
    end else if (int'(paddr) < RAM_DEPTH) begin
      region = region_ram;
    end else begin
      region = region_none;
    end
  end

  // rd_wait_q marks the second access cycle of a read
  assign first_access = psel && penable && !rd_wait_q;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_wait_q   <= 1'b0;
      rd_region_q <= region_none;
    end else begin
      rd_wait_q <= first_access && !pwrite;
      if (first_access && !pwrite) begin
        rd_region_q <= region;
      end
    end
  end

  // writes finish at once, reads take one wait state
  assign pready = (first_access && pwrite) || rd_wait_q;

  always_comb begin
    req.wr         = first_access && pwrite;
    req.strb       = pstrb;
    req.region     = region;
    req.addr       = paddr;
    req.wdata.half = pwdata;
  end

  // ram data lands one cycle after the address
  always_comb begin
    case (rd_region_q)
      region_ram: prdata = ram_rdata;
      region_io:  prdata = io_rdata;
      default:    prdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/data_ram.sv
`timescale 1ns/1ps
`default_nettype none

module data_ram
  import board_io_pkg::*;
#(
  parameter int RAM_DEPTH = 1024
) (
  input  wire logic     sys_clk,
  input  wire bus_req_t req,
  output bus_data_t     rdata
);

  localparam int IDX_W = $clog2(RAM_DEPTH);

  bus_data_t        mem [RAM_DEPTH];
  logic [IDX_W-1:0] idx;
  logic             wr_en;

  // region decode already limits the address to the ram range
  assign idx   = req.addr[IDX_W-1:0];
  assign wr_en = req.wr && (req.region == region_ram);

  // byte lanes are written independently
  always_ff @(posedge sys_clk) begin
    if (wr_en && req.strb[1]) begin
      mem[idx][15:8] <= req.wdata.half[15:8];
    end
    if (wr_en && req.strb[0]) begin
      mem[idx][7:0] <= req.wdata.half[7:0];
    end
  end

  // read every cycle, old data on a colliding write
  always_ff @(posedge sys_clk) begin
    rdata <= mem[idx];
  end

endmodule

`default_nettype wire

// File: hdl/io_regs.sv
`timescale 1ns/1ps
`default_nettype none

module io_regs
  import board_io_pkg::*;
(
  input  wire logic     sys_clk,
  input  wire logic     rst_n,
  input  wire bus_req_t req,
  output bus_data_t     rdata,
  output display_t      disp
);

  logic [7:0]  led;
  logic [7:0]  lcd;
  logic [7:0]  gpio;
  bus_data_t   last_wdata;
  logic [15:0] last_addr;
  logic        wr_io;

  assign wr_io = req.wr && (req.region == region_io);

  // byte strobes pick which register of a pair gets loaded
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      led  <= '0;
      lcd  <= '0;
      gpio <= '0;
    end else if (wr_io) begin
      case (req.addr)
        IO_LEDLCD_ADDR: begin
          if (req.strb[0]) led <= req.wdata.bytes.lo;
          if (req.strb[1]) lcd <= req.wdata.bytes.hi;
        end
        IO_LCD_ADDR: begin
          if (req.strb[1]) lcd <= req.wdata.bytes.hi;
        end
        IO_GPIO_ADDR: begin
          if (req.strb[0]) gpio <= req.wdata.bytes.lo;
        end
        default: ;
      endcase
    end
  end

  // any write anywhere is kept for the display
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      last_wdata <= '0;
      last_addr  <= '0;
    end else if (req.wr) begin
      last_wdata <= req.wdata.half;
      last_addr  <= {4'd0, req.addr};
    end
  end

  // register pairs decode on the address without bit 0
  always_comb begin
    if (req.addr[ADDR_W-1:1] == IO_LEDLCD_ADDR[ADDR_W-1:1]) begin
      rdata = {lcd, led};
    end else if (req.addr[ADDR_W-1:1] == IO_GPIO_ADDR[ADDR_W-1:1]) begin
      rdata = {8'd0, gpio};
    end else begin
      rdata = '0;
    end
  end

  assign disp = '{last_wdata: last_wdata, last_addr: last_addr,
                  led: led, lcd: lcd, gpio: gpio};

endmodule

`default_nettype wire

// File: hdl/led_matrix_scan.sv
`timescale 1ns/1ps
`default_nettype none

module led_matrix_scan
  import board_io_pkg::*;
#(
  parameter int PERIOD  = 27000,
  parameter int GAP_ON  = 100,
  parameter int GAP_OFF = 2000
) (
  input  wire logic     sys_clk,
  input  wire logic     rst_n,
  input  wire display_t disp,
  output logic [7:0]    led_row,
  output logic [7:0]    led_col
);

  localparam int CNT_W = $clog2(PERIOD);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(PERIOD - 1);
  localparam logic [CNT_W-1:0] ON_START = CNT_W'(GAP_ON);
  localparam logic [CNT_W-1:0] ON_END   = CNT_W'(PERIOD - GAP_OFF);

  logic [CNT_W-1:0] counter;
  logic [2:0]       row;
  logic             led_on;

  // segments a..g from bit 7 down, dot in bit 0
  function automatic logic [7:0] encode_7seg(input logic [3:0] n, input logic dot);
    logic [6:0] seg;
    case (n)
      4'h0: seg = 7'b1111110;
      4'h1: seg = 7'b0110000;
      4'h2: seg = 7'b1101101;
      4'h3: seg = 7'b1111001;
      4'h4: seg = 7'b0110011;
      4'h5: seg = 7'b1011011;
      4'h6: seg = 7'b1011111;
      4'h7: seg = 7'b1110000;
      4'h8: seg = 7'b1111111;
      4'h9: seg = 7'b1111011;
      4'ha: seg = 7'b1110111;
      4'hb: seg = 7'b0011111;
      4'hc: seg = 7'b1001110;
      4'hd: seg = 7'b0111101;
      4'he: seg = 7'b1001111;
      default: seg = 7'b1000111;
    endcase
    return {seg, dot};
  endfunction

  // row time counter, row steps on wrap
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      counter <= '0;
      row     <= '0;
    end else if (counter == CNT_LAST) begin
      counter <= '0;
      row     <= row + 3'd1;
    end else begin
      counter <= counter + 1'b1;
    end
  end

  // dark gap at both ends of each row so neighbours do not ghost
  assign led_on  = (counter >= ON_START) && (counter < ON_END);
  assign led_row = ~({7'd0, led_on} << row);

  always_comb begin
    case (row)
      3'd0:    led_col = disp.last_wdata[15:8];
      3'd1:    led_col = disp.last_wdata[7:0];
      3'd2:    led_col = disp.last_addr[15:8];
      3'd3:    led_col = disp.last_addr[7:0];
      3'd4:    led_col = disp.led;
      3'd5:    led_col = disp.lcd;
      3'd6:    led_col = disp.gpio;
      default: led_col = encode_7seg(disp.last_addr[3:0], disp.last_addr[4]);
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/board_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_io_top
  import board_io_pkg::*;
#(
  parameter int RAM_DEPTH = 1024,
  parameter int PERIOD    = 27000,
  parameter int GAP_ON    = 100,
  parameter int GAP_OFF   = 2000
) (
  input  wire logic       sys_clk,
  input  wire logic       rst_n,
  // apb slave
  input  wire logic       psel,
  input  wire logic       penable,
  input  wire logic       pwrite,
  input  wire bus_addr_t  paddr,
  input  wire bus_data_t  pwdata,
  input  wire logic [1:0] pstrb,
  output bus_data_t       prdata,
  output logic            pready,
  // board pins
  output logic [7:0]      led_row,
  output logic [7:0]      led_col,
  output logic            lcd_e,
  output logic            lcd_rw,
  output logic            lcd_rs,
  output logic [3:0]      lcd_db,
  output logic [7:0]      gpio
);

  bus_req_t  req;
  bus_data_t ram_rdata;
  bus_data_t io_rdata;
  display_t  disp;

  apb_mem_port #(.RAM_DEPTH(RAM_DEPTH)) u_port (
    .sys_clk(sys_clk), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite),
    .paddr(paddr), .pwdata(pwdata), .pstrb(pstrb),
    .prdata(prdata), .pready(pready), .req(req),
    .ram_rdata(ram_rdata), .io_rdata(io_rdata)
  );

  data_ram #(.RAM_DEPTH(RAM_DEPTH)) u_ram (
    .sys_clk(sys_clk), .req(req), .rdata(ram_rdata)
  );

  io_regs u_io (
    .sys_clk(sys_clk), .rst_n(rst_n), .req(req),
    .rdata(io_rdata), .disp(disp)
  );

  led_matrix_scan #(.PERIOD(PERIOD), .GAP_ON(GAP_ON), .GAP_OFF(GAP_OFF)) u_scan (
    .sys_clk(sys_clk), .rst_n(rst_n), .disp(disp),
    .led_row(led_row), .led_col(led_col)
  );

  // lcd in 4-bit mode, data on the upper nibble
  assign lcd_e  = disp.lcd[0];
  assign lcd_rw = disp.lcd[1];
  assign lcd_rs = disp.lcd[2];
  assign lcd_db = disp.lcd[7:4];
  assign gpio   = disp.gpio;

endmodule

`default_nettype wire

// File: sim/tb_board_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board_io
  import board_io_pkg::*;
();

  localparam int RAM_DEPTH = 256;
  localparam int PERIOD    = 40;
  localparam int GAP_ON    = 4;
  localparam int GAP_OFF   = 8;
  localparam int RAM_WORDS = 128;
  localparam int N_RAM     = 200;
  localparam int N_IO      = 60;
  localparam int N_UNM     = 40;
  // worst case transfer count over all five tests
  localparam int N_TRANS   = 2 + RAM_WORDS + 2 * N_RAM + 2 * N_IO + 2 * N_UNM + 2 + RAM_WORDS + 1;
  localparam int WATCHDOG_NS = (N_TRANS * 10 + 20 * PERIOD + 16) * 20;

  logic       sys_clk;
  logic       rst_n;
  logic       psel;
  logic       penable;
  logic       pwrite;
  bus_addr_t  paddr;
  bus_data_t  pwdata;
  logic [1:0] pstrb;
  bus_data_t  prdata;
  logic       pready;
  logic [7:0] led_row;
  logic [7:0] led_col;
  logic       lcd_e;
  logic       lcd_rw;
  logic       lcd_rs;
  logic [3:0] lcd_db;
  logic [7:0] gpio;

  logic [31:0] lfsr = 32'h86ab;
  int          errors = 0;
  int          checks = 0;
  int          tests_run = 0;

  // reference model state
  bus_data_t   ram_m [RAM_DEPTH];
  logic [7:0]  led_m = '0;
  logic [7:0]  lcd_m = '0;
  logic [7:0]  gpio_m = '0;
  bus_data_t   last_wdata_m = '0;
  logic [15:0] last_addr_m = '0;
  int          scan_cnt;
  logic [2:0]  scan_row;

  board_io_top #(
    .RAM_DEPTH(RAM_DEPTH), .PERIOD(PERIOD), .GAP_ON(GAP_ON), .GAP_OFF(GAP_OFF)
  ) dut (
    .sys_clk(sys_clk), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
    .pwdata(pwdata), .pstrb(pstrb), .prdata(prdata), .pready(pready),
    .led_row(led_row), .led_col(led_col), .lcd_e(lcd_e), .lcd_rw(lcd_rw),
    .lcd_rs(lcd_rs), .lcd_db(lcd_db), .gpio(gpio)
  );

  initial sys_clk = 1'b0;
  always #10 sys_clk = ~sys_clk;

  // reference row counter and row index
  always @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      scan_cnt <= 0;
      scan_row <= 3'd0;
    end else if (scan_cnt == PERIOD - 1) begin
      scan_cnt <= 0;
      scan_row <= scan_row + 3'd1;
    end else begin
      scan_cnt <= scan_cnt + 1;
    end
  end

  // galois lfsr stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [7:0] seg7_glyph(input logic [3:0] n, input logic dot);
    logic [7:0] g;
    case (n)
      4'h0: g = 8'hfc;
      4'h1: g = 8'h60;
      4'h2: g = 8'hda;
      4'h3: g = 8'hf2;
      4'h4: g = 8'h66;
      4'h5: g = 8'hb6;
      4'h6: g = 8'hbe;
      4'h7: g = 8'he0;
      4'h8: g = 8'hfe;
      4'h9: g = 8'hf6;
      4'ha: g = 8'hee;
      4'hb: g = 8'h3e;
      4'hc: g = 8'h9c;
      4'hd: g = 8'h7a;
      4'he: g = 8'h9e;
      default: g = 8'h8e;
    endcase
    return g | {7'd0, dot};
  endfunction

  function automatic logic [7:0] expected_col(input logic [2:0] row);
    case (row)
      3'd0: return last_wdata_m[15:8];
      3'd1: return last_wdata_m[7:0];
      3'd2: return last_addr_m[15:8];
      3'd3: return last_addr_m[7:0];
      3'd4: return led_m;
      3'd5: return lcd_m;
      3'd6: return gpio_m;
      default: return seg7_glyph(last_addr_m[3:0], last_addr_m[4]);
    endcase
  endfunction

  function automatic bus_data_t model_read(input bus_addr_t a);
    if (a == 12'h080 || a == 12'h081) return {lcd_m, led_m};
    if (a == 12'h082 || a == 12'h083) return {8'd0, gpio_m};
    if (a >= 12'h080 && a <= 12'h0ff) return '0;
    if (int'(a) < RAM_DEPTH) return ram_m[a[7:0]];
    return '0;
  endfunction

  function automatic void model_write(input bus_addr_t a, input bus_data_t d,
                                      input logic [1:0] s);
    last_wdata_m = d;
    last_addr_m  = {4'd0, a};
    if (a >= 12'h080 && a <= 12'h0ff) begin
      if (a == 12'h080 && s[0]) led_m = d[7:0];
      if ((a == 12'h080 || a == 12'h081) && s[1]) lcd_m = d[15:8];
      if (a == 12'h082 && s[0]) gpio_m = d[7:0];
    end else if (int'(a) < RAM_DEPTH) begin
      if (s[1]) ram_m[a[7:0]][15:8] = d[15:8];
      if (s[0]) ram_m[a[7:0]][7:0] = d[7:0];
    end
  endfunction

  task automatic check_eq(input logic [15:0] got, input logic [15:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      $display("error at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  // setup on one falling edge, access on the next, sample at rising edges
  task automatic apb_xfer(input logic wr, input bus_addr_t a, input bus_data_t d,
                          input logic [1:0] s, output bus_data_t rd, output int waits);
    @(negedge sys_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = a;
    pwdata  = d;
    pstrb   = s;
    @(negedge sys_clk);
    penable = 1'b1;
    waits   = 0;
    @(posedge sys_clk);
    while (!pready) begin
      waits++;
      @(posedge sys_clk);
    end
    rd = prdata;
    @(negedge sys_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic do_write(input bus_addr_t a, input bus_data_t d, input logic [1:0] s);
    bus_data_t rd;
    int        waits;
    apb_xfer(1'b1, a, d, s, rd, waits);
    model_write(a, d, s);
    check_eq(16'(waits), 16'd0, $sformatf("write wait states at %h", a));
  endtask

  task automatic read_check(input bus_addr_t a, input string what);
    bus_data_t rd;
    int        waits;
    apb_xfer(1'b0, a, '0, 2'b00, rd, waits);
    check_eq(rd, model_read(a), $sformatf("%s at %h", what, a));
    check_eq(16'(waits), 16'd1, $sformatf("read wait states at %h", a));
  endtask

  task automatic check_pins();
    check_eq(16'(gpio), 16'(gpio_m), "gpio pins");
    check_eq(16'({lcd_db, lcd_rs, lcd_rw, lcd_e}),
             16'({lcd_m[7:4], lcd_m[2], lcd_m[1], lcd_m[0]}), "lcd pins");
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    $display("test %s finished with %0d errors", name, errors - err_before);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, a transfer or the scan never finished",
             WATCHDOG_NS);
    $display("tests failed");
    $finish;
  end

  initial begin
    bus_addr_t  a;
    bus_data_t  d;
    logic [1:0] s;
    int         err0;
    int         prev_row;
    int         lit;
    logic       on;
    logic [7:0] exp_row;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    pstrb   = 2'b00;
    repeat (16) @(negedge sys_clk);
    rst_n = 1'b1;

    err0 = errors;
    check_eq(16'(led_row), 16'h00ff, "led_row in gap after reset");
    check_pins();
    read_check(12'h080, "reset led/lcd");
    read_check(12'h082, "reset gpio");
    end_test("reset", err0);

    err0 = errors;
    // fill pattern so that every ram word has a known value
    for (int i = 0; i < RAM_WORDS; i++) begin
      a = 12'(i);
      do_write(a, {a, ~a[11:8]}, 2'b11);
    end
    for (int i = 0; i < N_RAM; i++) begin
      a = 12'(rand_bits(7));
      d = 16'(rand_bits(16));
      s = 2'(rand_bits(2));
      do_write(a, d, s);
      if (rand_bits(1)) begin
        a = 12'(rand_bits(7));
        read_check(a, "ram read");
      end
    end
    end_test("ram", err0);

    err0 = errors;
    for (int i = 0; i < N_IO; i++) begin
      case (rand_bits(2))
        0: a = 12'h080;
        1: a = 12'h081;
        default: a = 12'h082;
      endcase
      d = 16'(rand_bits(16));
      s = 2'(rand_bits(2));
      do_write(a, d, s);
      check_pins();
      a = 12'h080 + 12'(rand_bits(2));
      read_check(a, "io read");
    end
    end_test("io_regs", err0);

    err0 = errors;
    for (int i = 0; i < N_UNM; i++) begin
      if (rand_bits(1)) a = 12'h084 + 12'(rand_bits(7) % 124);
      else a = 12'h100 + 12'(rand_bits(12) % 3840);
      d = 16'(rand_bits(16));
      s = 2'(rand_bits(2));
      do_write(a, d, s);
      read_check(a, "unmapped read");
    end
    check_pins();
    read_check(12'h080, "io after unmapped");
    read_check(12'h082, "io after unmapped");
    // every ram word must still hold its model value
    for (int i = 0; i < RAM_WORDS; i++) begin
      a = 12'(i);
      read_check(a, "ram after unmapped");
    end
    end_test("unmapped", err0);

    err0 = errors;
    a = 12'(rand_bits(12));
    d = 16'(rand_bits(16));
    s = 2'(rand_bits(2));
    do_write(a, d, s);
    prev_row = -1;
    repeat (16 * PERIOD) begin
      @(negedge sys_clk);
      on = (scan_cnt >= GAP_ON) && (scan_cnt < PERIOD - GAP_OFF);
      exp_row = on ? ~(8'd1 << scan_row) : 8'hff;
      check_eq(16'(led_row), 16'(exp_row), "led_row");
      check_eq(16'(led_col), 16'(expected_col(scan_row)), "led_col");
      if (led_row != 8'hff) begin
        check_true($countones(~led_row) == 1, "more than one row line is low");
        lit = 0;
        for (int k = 0; k < 8; k++) begin
          if (!led_row[k]) lit = k;
        end
        if (prev_row >= 0 && lit != prev_row) begin
          check_true(lit == (prev_row + 1) % 8, "scanner skipped a row");
        end
        prev_row = lit;
      end
    end
    end_test("scanner", err0);

    $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
hdl/board_io_pkg.sv
hdl/apb_mem_port.sv
hdl/data_ram.sv
hdl/io_regs.sv
hdl/led_matrix_scan.sv
hdl/board_io_top.sv
sim/tb_board_io.sv

// File: Bender.yml
package:
  name: board_io

sources:
  - hdl/board_io_pkg.sv
  - hdl/apb_mem_port.sv
  - hdl/data_ram.sv
  - hdl/io_regs.sv
  - hdl/led_matrix_scan.sv
  - hdl/board_io_top.sv
  - target: simulation
    files:
      - sim/tb_board_io.sv
